/* logic/cfo_derotator.sv */
`timescale 1ns/1ps

module cfo_derotator (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  iq_pkg::iq_sample_t  sample_i,
    input  logic                sample_valid_i,
    output logic                sample_ready_o,

    input  cfo_pkg::cfo_update_t cfo_update_i,

    output iq_pkg::iq_sample_t  rot_o,
    output logic                rot_valid_o,
    input  logic                rot_ready_i
);
    import iq_pkg::*;
    import cfo_pkg::*;

    logic signed [phase_dw-1:0] inc_q;
    logic [phase_dw-1:0]        phase_q;
    quadrant_t                  quadrant;
    logic                       accept;

    // negation that maps the most negative value to full scale
    function automatic logic signed [iq_dw-1:0] neg_sat(input logic signed [iq_dw-1:0] x);
        return (x == iq_min) ? iq_max : -x;
    endfunction

    function automatic iq_sample_t rotate(input iq_sample_t s, input quadrant_t quad);
        iq_sample_t r;
        case (quad)
            rot_0: begin
                r = s;
            end
            rot_90: begin
                r.i = neg_sat(s.q);
                r.q = s.i;
            end
            rot_180: begin
                r.i = neg_sat(s.i);
                r.q = neg_sat(s.q);
            end
            rot_270: begin
                r.i = s.q;
                r.q = neg_sat(s.i);
            end
        endcase
        return r;
    endfunction

    assign sample_ready_o = !rot_valid_o || rot_ready_i;
    assign accept         = sample_valid_i && sample_ready_o;
    assign quadrant       = quadrant_t'(phase_q[phase_dw-1 -: 2]);

    // ------------------------------------------------------------------------
    // phase and increment
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_q       <= '0;
            phase_q     <= '0;
            rot_valid_o <= 1'b0;
        end else begin
            // updates are relative to the previous correction
            if (cfo_update_i.valid) begin
                inc_q <= inc_q - cfo_update_i.inc;
            end
            if (accept) begin
                phase_q <= phase_q + inc_q;
            end
            if (accept) begin
                rot_valid_o <= 1'b1;
            end else if (rot_ready_i) begin
                rot_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rot_o <= rotate(sample_i, quadrant);
        end
    end

endmodule

/* logic/cfo_pkg.sv */
package cfo_pkg;

    // phase accumulator width, one turn is 2**phase_dw
    localparam int unsigned phase_dw = 20;

    // relative correction, applied whenever valid is set
    typedef struct packed {
        logic                       valid;
        logic signed [phase_dw-1:0] inc;
    } cfo_update_t;

    // top two phase bits
    typedef enum logic [1:0] {
        rot_0   = 2'd0,
        rot_90  = 2'd1,
        rot_180 = 2'd2,
        rot_270 = 2'd3
    } quadrant_t;

endpackage

/* logic/cic_decimator.sv */
`timescale 1ns/1ps

module cic_decimator #(
    parameter int unsigned CIC_RATE   = 2,
    parameter int unsigned CIC_STAGES = 3
) (
    input  logic               clk_i,
    input  logic               reset_ni,

    input  iq_pkg::iq_sample_t in_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,

    output iq_pkg::iq_sample_t out_o,
    output logic               out_valid_o,
    input  logic               out_ready_i
);
    import iq_pkg::*;

    // bit growth of the filter with differential delay one
    localparam int unsigned growth = CIC_STAGES * $clog2(CIC_RATE);
    localparam int unsigned acc_dw = iq_dw + growth;
    localparam int unsigned cnt_dw = (CIC_RATE > 1) ? $clog2(CIC_RATE) : 1;

    typedef logic signed [acc_dw-1:0] acc_t;

    logic              accept;
    logic              dump;
    logic [cnt_dw-1:0] cnt_q;

    // index 0 is I, index 1 is Q
    acc_t comp_in  [2];
    acc_t integ_q  [2][CIC_STAGES];
    acc_t integ_d  [2][CIC_STAGES];
    acc_t comb_q   [2][CIC_STAGES];
    acc_t comb_in  [2][CIC_STAGES];
    acc_t comb_out [2][CIC_STAGES];
    acc_t scaled   [2];

    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;
    // last input of a decimation period
    assign dump       = accept && (cnt_q == cnt_dw'(CIC_RATE - 1));

    assign comp_in[0] = acc_t'(in_i.i);
    assign comp_in[1] = acc_t'(in_i.q);

    // ------------------------------------------------------------------------
    // integrator cascade, then comb cascade on the newest integrator value
    // ------------------------------------------------------------------------

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            integ_d[c][0] = integ_q[c][0] + comp_in[c];
            for (int s = 1; s < CIC_STAGES; s++) begin
                integ_d[c][s] = integ_q[c][s] + integ_d[c][s-1];
            end

            comb_in[c][0]  = integ_d[c][CIC_STAGES-1];
            comb_out[c][0] = comb_in[c][0] - comb_q[c][0];
            for (int s = 1; s < CIC_STAGES; s++) begin
                comb_in[c][s]  = comb_out[c][s-1];
                comb_out[c][s] = comb_in[c][s] - comb_q[c][s];
            end

            // remove the gain of CIC_RATE**CIC_STAGES
            scaled[c] = comb_out[c][CIC_STAGES-1] >>> growth;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cnt_q       <= '0;
            integ_q     <= '{default: '0};
            comb_q      <= '{default: '0};
            out_valid_o <= 1'b0;
        end else begin
            if (accept) begin
                cnt_q   <= dump ? '0 : cnt_q + 1'b1;
                integ_q <= integ_d;
            end
            if (dump) begin
                comb_q <= comb_in;
            end
            if (dump) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dump) begin
            out_o.i <= scaled[0][iq_dw-1:0];
            out_o.q <= scaled[1][iq_dw-1:0];
        end
    end

endmodule

/* logic/iq_pkg.sv */
package iq_pkg;

    // ------------------------------------------------------------------------
    // complex sample stream
    // ------------------------------------------------------------------------

    // width of one component, I or Q
    localparam int unsigned iq_dw = 16;

    // full scale of one component
    localparam logic signed [iq_dw-1:0] iq_max = {1'b0, {(iq_dw - 1){1'b1}}};
    localparam logic signed [iq_dw-1:0] iq_min = {1'b1, {(iq_dw - 1){1'b0}}};

    // real part in the low half, imaginary part in the high half
    typedef struct packed {
        logic signed [iq_dw-1:0] q;
        logic signed [iq_dw-1:0] i;
    } iq_sample_t;

    // ------------------------------------------------------------------------
    // soft bit stream
    // ------------------------------------------------------------------------

    localparam int unsigned llr_dw = 8;

    // most negative code, never sent
    localparam logic signed [llr_dw-1:0] llr_min = {1'b1, {(llr_dw - 1){1'b0}}};

    // two beats per sample, last marks the Q beat
    typedef struct packed {
        logic signed [llr_dw-1:0] llr;
        logic                     last;
    } llr_beat_t;

endpackage

/* logic/llr_demapper.sv */
`timescale 1ns/1ps

module llr_demapper (
    input  logic               clk_i,
    input  logic               reset_ni,

    input  iq_pkg::iq_sample_t in_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,

    output iq_pkg::llr_beat_t  llr_o,
    output logic               llr_valid_o,
    input  logic               llr_ready_i
);
    import iq_pkg::*;

    iq_sample_t              sample_q;
    // low while the I beat is pending, high for the Q beat
    logic                    beat_q;
    logic                    accept;
    logic                    take;
    logic signed [iq_dw-1:0] comp;

    // keep the top llr_dw bits, symmetric range
    function automatic logic signed [llr_dw-1:0] to_llr(input logic signed [iq_dw-1:0] x);
        logic signed [iq_dw-1:0]  shifted;
        logic signed [llr_dw-1:0] code;
        shifted = x >>> (iq_dw - llr_dw);
        code    = shifted[llr_dw-1:0];
        if (code == llr_min) begin
            code = llr_min + 1;
        end
        return code;
    endfunction

    assign take       = llr_valid_o && llr_ready_i;
    // a new sample only enters together with the Q beat leaving
    assign in_ready_o = !llr_valid_o || (beat_q && llr_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    assign comp       = beat_q ? sample_q.q : sample_q.i;
    assign llr_o.llr  = to_llr(comp);
    assign llr_o.last = beat_q;

    // ------------------------------------------------------------------------
    // beat sequencing
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            llr_valid_o <= 1'b0;
            beat_q      <= 1'b0;
        end else begin
            if (accept) begin
                llr_valid_o <= 1'b1;
                beat_q      <= 1'b0;
            end else if (take) begin
                if (beat_q) begin
                    llr_valid_o <= 1'b0;
                    beat_q      <= 1'b0;
                end else begin
                    beat_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            sample_q <= in_i;
        end
    end

endmodule

/* logic/receiver_frontend.sv */
`timescale 1ns/1ps

module receiver_frontend #(
    parameter int unsigned CIC_RATE   = 2,
    parameter int unsigned CIC_STAGES = 3
) (
    input  logic                 clk_i,
    input  logic                 reset_ni,

    input  iq_pkg::iq_sample_t   sample_i,
    input  logic                 sample_valid_i,
    output logic                 sample_ready_o,

    input  cfo_pkg::cfo_update_t cfo_update_i,

    output iq_pkg::llr_beat_t    llr_o,
    output logic                 llr_valid_o,
    input  logic                 llr_ready_i
);
    import iq_pkg::*;

    // derotated samples at the input rate
    iq_sample_t rot;
    logic       rot_valid;
    logic       rot_ready;

    // decimated samples
    iq_sample_t cic_out;
    logic       cic_valid;
    logic       cic_ready;

    cfo_derotator i_cfo_derotator (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .sample_ready_o(sample_ready_o),
        .cfo_update_i  (cfo_update_i),
        .rot_o         (rot),
        .rot_valid_o   (rot_valid),
        .rot_ready_i   (rot_ready)
    );

    cic_decimator #(
        .CIC_RATE  (CIC_RATE),
        .CIC_STAGES(CIC_STAGES)
    ) i_cic_decimator (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_i       (rot),
        .in_valid_i (rot_valid),
        .in_ready_o (rot_ready),
        .out_o      (cic_out),
        .out_valid_o(cic_valid),
        .out_ready_i(cic_ready)
    );

    llr_demapper i_llr_demapper (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_i       (cic_out),
        .in_valid_i (cic_valid),
        .in_ready_o (cic_ready),
        .llr_o      (llr_o),
        .llr_valid_o(llr_valid_o),
        .llr_ready_i(llr_ready_i)
    );

endmodule

/* sources.f */
+incdir+verification
logic/iq_pkg.sv
logic/cfo_pkg.sv
logic/cfo_derotator.sv
logic/cic_decimator.sv
logic/llr_demapper.sv
logic/receiver_frontend.sv
verification/receiver_frontend_tb.sv

/* verification/frontend_model.svh */
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// ------------------------------------------------------------------------
// random source, 16 bit Galois LFSR
// ------------------------------------------------------------------------

logic [15:0] lfsr_q = 16'd57414;

function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
        lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out;
endfunction

// one step per bit, first bit ends up on top
function automatic logic [31:0] lfsr_word(input int unsigned n);
    logic [31:0] w;
    w = '0;
    for (int unsigned b = 0; b < n; b++) begin
        w = {w[30:0], lfsr_bit()};
    end
    return w;
endfunction

// ------------------------------------------------------------------------
// reference model state
// ------------------------------------------------------------------------

logic [phase_dw-1:0]        phase_m = '0;
logic signed [phase_dw-1:0] inc_m   = '0;
longint                     integ_m [2][cic_stages] = '{default: 0};
longint                     comb_m  [2][cic_stages] = '{default: 0};
int                         count_m = 0;

function automatic iq_sample_t rotate_model(input iq_sample_t s, input quadrant_t quad);
    int         i;
    int         q;
    int         ri;
    int         rq;
    iq_sample_t r;
    i = s.i;
    q = s.q;
    case (quad)
        rot_90: begin
            ri = -q;
            rq = i;
        end
        rot_180: begin
            ri = -i;
            rq = -q;
        end
        rot_270: begin
            ri = q;
            rq = -i;
        end
        default: begin
            ri = i;
            rq = q;
        end
    endcase
    // only the negated minimum leaves the range
    ri = (ri > int'(iq_max)) ? int'(iq_max) : ri;
    rq = (rq > int'(iq_max)) ? int'(iq_max) : rq;
    r.i = ri[iq_dw-1:0];
    r.q = rq[iq_dw-1:0];
    return r;
endfunction

// returns 1 when a decimated sample comes out
function automatic logic cic_push(input iq_sample_t s, output iq_sample_t y);
    longint x [2];
    longint v;
    longint d;
    x[0] = s.i;
    x[1] = s.q;
    y    = '0;
    for (int c = 0; c < 2; c++) begin
        integ_m[c][0] += x[c];
        for (int st = 1; st < cic_stages; st++) begin
            integ_m[c][st] += integ_m[c][st-1];
        end
    end
    count_m++;
    if (count_m < cic_rate) begin
        return 1'b0;
    end
    count_m = 0;
    for (int c = 0; c < 2; c++) begin
        v = integ_m[c][cic_stages-1];
        for (int st = 0; st < cic_stages; st++) begin
            d            = v - comb_m[c][st];
            comb_m[c][st] = v;
            v            = d;
        end
        v = v >>> (cic_stages * $clog2(cic_rate));
        if (c == 0) begin
            y.i = v[iq_dw-1:0];
        end else begin
            y.q = v[iq_dw-1:0];
        end
    end
    return 1'b1;
endfunction

function automatic logic signed [llr_dw-1:0] llr_model(input logic signed [iq_dw-1:0] x);
    int v;
    v = x;
    v = v >>> (iq_dw - llr_dw);
    if (v == int'(llr_min)) begin
        v = v + 1;
    end
    return v[llr_dw-1:0];
endfunction

// one accepted input sample, expected beats go to the queue
function automatic void model_sample(input iq_sample_t s);
    iq_sample_t r;
    iq_sample_t y;
    llr_beat_t  b;
    r       = rotate_model(s, quadrant_t'(phase_m[phase_dw-1 -: 2]));
    phase_m = phase_m + inc_m;
    if (cic_push(r, y)) begin
        b.llr  = llr_model(y.i);
        b.last = 1'b0;
        expected_q.push_back(b);
        b.llr  = llr_model(y.q);
        b.last = 1'b1;
        expected_q.push_back(b);
    end
endfunction

`endif

/* verification/receiver_frontend_tb.sv */
`timescale 1ns/1ps

module receiver_frontend_tb;
    import iq_pkg::*;
    import cfo_pkg::*;

    localparam int unsigned cic_rate      = 2;
    localparam int unsigned cic_stages    = 3;
    localparam int unsigned burst_len     = 32;
    localparam int unsigned fs_len        = 8;
    // five bursts, three full-scale runs, two steering samples
    localparam int unsigned total_samples = 5 * burst_len + 3 * fs_len + 2;
    localparam int unsigned cycle_limit   = 4 * total_samples + 200;
    // four samples per quadrant
    localparam logic signed [phase_dw-1:0] quarter_step = 1 << (phase_dw - 4);
    localparam logic [phase_dw-1:0]        half_turn    = 1 << (phase_dw - 1);

    logic        clk_i;
    logic        reset_ni;
    iq_sample_t  sample_i;
    logic        sample_valid_i;
    logic        sample_ready_o;
    cfo_update_t cfo_update_i;
    llr_beat_t   llr_o;
    logic        llr_valid_o;
    logic        llr_ready_i;

    llr_beat_t   expected_q [$];
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int unsigned cycles          = 0;
    logic        random_valid    = 1'b0;
    logic        random_ready    = 1'b0;
    logic        stalled_q       = 1'b0;
    llr_beat_t   held_q;

    `include "frontend_model.svh"

    receiver_frontend #(
        .CIC_RATE  (cic_rate),
        .CIC_STAGES(cic_stages)
    ) i_receiver_frontend (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .sample_ready_o(sample_ready_o),
        .cfo_update_i  (cfo_update_i),
        .llr_o         (llr_o),
        .llr_valid_o   (llr_valid_o),
        .llr_ready_i   (llr_ready_i)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (random_ready) begin
            llr_ready_i <= lfsr_bit();
        end else begin
            llr_ready_i <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // model and scoreboard
    // ------------------------------------------------------------------------

    always @(posedge clk_i) begin
        llr_beat_t exp_beat;
        if (reset_ni) begin
            if (sample_valid_i && sample_ready_o) begin
                model_sample(sample_i);
            end
            if (cfo_update_i.valid) begin
                inc_m = inc_m - cfo_update_i.inc;
            end
            if (stalled_q) begin
                assert (llr_valid_o && llr_o == held_q) else begin
                    protocol_errors++;
                    $display("Error at %0t ns: LLR beat changed while stalled", $time);
                end
            end
            if (llr_valid_o && llr_ready_i) begin
                if (expected_q.size() == 0) begin
                    protocol_errors++;
                    $display("an extra LLR beat left the DUT at %0t ns", $time);
                end else begin
                    exp_beat = expected_q.pop_front();
                    assert (llr_o == exp_beat) else begin
                        value_errors++;
                        $display("Error at %0t ns: llr %0d last %0b, expected llr %0d last %0b",
                                 $time, llr_o.llr, llr_o.last, exp_beat.llr, exp_beat.last);
                    end
                end
            end
            stalled_q <= llr_valid_o && !llr_ready_i;
            held_q    <= llr_o;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles with %0d beats still expected",
                     cycle_limit, expected_q.size());
            $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic push_samples(input int unsigned count, input logic use_fill,
                                input iq_sample_t fill);
        int unsigned sent;
        logic        holding;
        sent    = 0;
        holding = 1'b0;
        while (sent < count) begin
            @(posedge clk_i);
            if (holding && sample_ready_o) begin
                sent++;
                holding = 1'b0;
            end
            if (!holding && sent < count && (!random_valid || lfsr_bit())) begin
                sample_i       <= use_fill ? fill : iq_sample_t'(lfsr_word(2 * iq_dw));
                sample_valid_i <= 1'b1;
                holding        = 1'b1;
            end else if (!holding) begin
                sample_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic send_update(input logic signed [phase_dw-1:0] inc);
        @(posedge clk_i);
        cfo_update_i.inc   <= inc;
        cfo_update_i.valid <= 1'b1;
        @(posedge clk_i);
        cfo_update_i.valid <= 1'b0;
    endtask

    // one sample lands the phase on goal, then the increment goes back to zero
    task automatic steer_phase(input logic [phase_dw-1:0] goal);
        logic signed [phase_dw-1:0] step;
        @(posedge clk_i);
        step = goal - phase_m;
        send_update(inc_m - step);
        push_samples(1, 1'b0, '0);
        send_update(inc_m);
    endtask

    initial begin
        logic signed [phase_dw-1:0] drift;
        iq_sample_t                 full_neg;
        iq_sample_t                 full_pos;
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        cfo_update_i   = '0;
        llr_ready_i    = 1'b1;
        full_neg.i     = iq_min;
        full_neg.q     = iq_min;
        full_pos.i     = iq_max;
        full_pos.q     = iq_max;

        repeat (3) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(posedge clk_i);
        assert (!llr_valid_o && sample_ready_o) else begin
            protocol_errors++;
            $display("Error at %0t ns: DUT not idle after reset", $time);
        end

        push_samples(burst_len, 1'b0, '0);
        random_valid = 1'b1;
        random_ready = 1'b1;
        push_samples(burst_len, 1'b0, '0);

        // rotating phase, then a random offset and its cancellation
        send_update(-quarter_step);
        push_samples(burst_len, 1'b0, '0);
        drift = phase_dw'(lfsr_word(phase_dw));
        send_update(drift);
        push_samples(burst_len, 1'b0, '0);
        send_update(-drift);
        push_samples(burst_len, 1'b0, '0);

        // full scale at quadrant 0, then the negative run at quadrant 2
        steer_phase('0);
        push_samples(fs_len, 1'b1, full_neg);
        push_samples(fs_len, 1'b1, full_pos);
        steer_phase(half_turn);
        push_samples(fs_len, 1'b1, full_neg);

        @(posedge clk_i);
        while (expected_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (8) @(posedge clk_i);

        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
